/* project.f */
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/reg_file.sv
logic/mycpu_top.sv
verif/cpu_checker.sv
verif/tb_top.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_top -f project.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/tb_top.sv */
module tb_top import cpu_pkg::*; ();

    localparam int ROM_WORDS = 256;
    localparam int RAM_WORDS = 256;
    localparam int N_SEC     = 4;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] num;
        logic [XLEN-1:0]   data;
        logic [1:0]        sec;
    } exp_t;

    logic              clk;
    logic              arst_n;
    logic              inst_sram_en;
    logic [XLEN-1:0]   inst_sram_addr;
    logic [XLEN-1:0]   inst_sram_rdata;
    logic              data_sram_en;
    logic [3:0]        data_sram_wen;
    logic [XLEN-1:0]   data_sram_addr;
    logic [XLEN-1:0]   data_sram_wdata;
    logic [XLEN-1:0]   data_sram_rdata;
    logic [XLEN-1:0]   debug_wb_pc;
    logic [3:0]        debug_wb_rf_wen;
    logic [REG_AW-1:0] debug_wb_rf_wnum;
    logic [XLEN-1:0]   debug_wb_rf_wdata;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] model_mem [RAM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] rng;
    exp_t        exp_q [$];
    int          n_words;
    int          cycles;
    int          other_err;
    int          sec_start [N_SEC+1];
    int          sec_total [N_SEC];
    int          sec_seen [N_SEC];
    int          sec_err [N_SEC];
    string       sec_name [N_SEC] = '{"alu", "memory", "branch", "reg0"};

    mycpu_top #(.RESET_PC(32'h0)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles <= cycles + 1;
        end
        if (inst_sram_en) begin
            inst_sram_rdata <= rom[inst_sram_addr[9:2]];
        end
    end

    // Byte-writable data RAM, read data one cycle later
    always @(posedge clk) begin
        if (data_sram_en) begin
            for (int b = 0; b < 4; b++) begin
                if (data_sram_wen[b]) begin
                    ram[data_sram_addr[9:2]][b*8 +: 8] <= data_sram_wdata[b*8 +: 8];
                end
            end
            data_sram_rdata <= ram[data_sram_addr[9:2]];
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = rand32();
        return 5'(1 + (v % 7));   // r1..r7 keeps dependencies dense
    endfunction

    function automatic logic [31:0] rtype(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [4:0] sa,
                                         input funct_e f);
        return {6'h00, rs, rt, rd, sa, f};
    endfunction

    function automatic logic [31:0] itype(input opcode_e op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jtype(input opcode_e op, input int idx);
        return {op, 26'(idx)};
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[n_words] = w;
        n_words++;
    endtask

    task automatic gen_program();
        logic [31:0] rv;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        sec_start[0] = n_words;
        for (int r = 1; r < 8; r++) begin
            rv = rand32();
            emit(itype(OP_ADDIU, 5'd0, 5'(r), rv[15:0]));
        end
        emit(rtype(5'd2, 5'd3, 5'd1, 5'd0, F_ADDU));
        emit(rtype(5'd1, 5'd2, 5'd4, 5'd0, F_SUBU));   // From execute
        emit(rtype(5'd1, 5'd4, 5'd5, 5'd0, F_XOR));    // Memory and execute
        emit(rtype(5'd1, 5'd5, 5'd6, 5'd0, F_OR));     // r1 from writeback
        for (int k = 0; k < 16; k++) begin
            rv = rand32();
            rd = pick_reg();
            rs = pick_reg();
            rt = pick_reg();
            case (rv[2:0])
                3'd0: emit(rtype(rs, rt, rd, 5'd0, F_ADDU));
                3'd1: emit(rtype(rs, rt, rd, 5'd0, F_SUBU));
                3'd2: emit(rtype(rs, rt, rd, 5'd0, F_AND));
                3'd3: emit(rtype(rs, rt, rd, 5'd0, F_OR));
                3'd4: emit(rtype(rs, rt, rd, 5'd0, F_XOR));
                3'd5: emit(rtype(rs, rt, rd, 5'd0, F_SLT));
                3'd6: emit(rtype(5'd0, rt, rd, rv[12:8], F_SLL));
                default: begin
                    if (rv[3]) emit(itype(OP_LUI, 5'd0, rd, rv[31:16]));
                    else       emit(itype(OP_ADDIU, rs, rd, rv[31:16]));
                end
            endcase
        end
        sec_start[1] = n_words;
        rv = rand32();
        emit(itype(OP_ADDIU, 5'd0, 5'd8, 16'h0040));
        emit(itype(OP_ADDIU, 5'd0, 5'd2, {9'h000, 7'h7f & rv[6:0]} | 16'h0080));
        emit(itype(OP_SW, 5'd8, 5'd1, 16'h0000));
        emit(itype(OP_SB, 5'd8, 5'd2, 16'h0005));
        emit(itype(OP_LW, 5'd8, 5'd4, 16'h0000));
        emit(rtype(5'd4, 5'd1, 5'd5, 5'd0, F_ADDU));   // Load-use
        emit(itype(OP_LB, 5'd8, 5'd6, 16'h0005));
        emit(itype(OP_LBU, 5'd8, 5'd7, 16'h0005));
        emit(rtype(5'd7, 5'd6, 5'd9, 5'd0, F_ADDU));
        emit(itype(OP_SW, 5'd8, 5'd3, 16'h0008));
        emit(itype(OP_LB, 5'd8, 5'd10, 16'h000b));
        emit(itype(OP_ADDIU, 5'd10, 5'd10, 16'h0001));
        emit(itype(OP_LBU, 5'd8, 5'd9, 16'h0043));    // Untouched fill data
        emit(itype(OP_LB, 5'd8, 5'd11, 16'h0042));
        sec_start[2] = n_words;
        rv = rand32();
        emit(itype(OP_ADDIU, 5'd0, 5'd11, rv[15:0]));
        emit(rtype(5'd11, 5'd0, 5'd12, 5'd0, F_ADDU));
        emit(itype(OP_BEQ, 5'd11, 5'd12, 16'd2));     // Taken
        emit(itype(OP_ADDIU, 5'd0, 5'd13, 16'd1));
        emit(itype(OP_ADDIU, 5'd0, 5'd13, 16'd2));
        emit(itype(OP_BNE, 5'd11, 5'd12, 16'd2));     // Not taken
        emit(itype(OP_ADDIU, 5'd11, 5'd14, 16'd1));
        emit(itype(OP_ADDIU, 5'd14, 5'd14, 16'd1));
        emit(itype(OP_BNE, 5'd11, 5'd0, 16'd2));
        emit(itype(OP_ADDIU, 5'd0, 5'd15, 16'd3));
        emit(itype(OP_ADDIU, 5'd0, 5'd15, 16'd4));
        emit(itype(OP_BEQ, 5'd12, 5'd0, 16'd2));
        emit(itype(OP_ADDIU, 5'd15, 5'd15, 16'd5));
        emit(jtype(OP_J, n_words + 3));
        emit(itype(OP_ADDIU, 5'd0, 5'd13, 16'd6));
        emit(itype(OP_ADDIU, 5'd0, 5'd13, 16'd7));
        emit(jtype(OP_JAL, n_words + 3));
        emit(itype(OP_ADDIU, 5'd0, 5'd14, 16'd8));
        emit(itype(OP_ADDIU, 5'd0, 5'd14, 16'd9));
        emit(rtype(5'd31, 5'd0, 5'd16, 5'd0, F_ADDU));
        emit(itype(OP_ADDIU, 5'd0, 5'd17, 16'((n_words + 4) * 4)));
        emit(rtype(5'd17, 5'd0, 5'd0, 5'd0, F_JR));
        emit(itype(OP_ADDIU, 5'd0, 5'd18, 16'd10));
        emit(itype(OP_ADDIU, 5'd0, 5'd18, 16'd11));
        emit(itype(OP_ADDIU, 5'd18, 5'd19, 16'd12));
        sec_start[3] = n_words;
        emit(itype(OP_ADDIU, 5'd1, 5'd0, 16'd5));
        emit(rtype(5'd1, 5'd2, 5'd0, 5'd0, F_ADDU));
        emit(itype(OP_LW, 5'd8, 5'd0, 16'h0000));
        emit(rtype(5'd0, 5'd0, 5'd20, 5'd0, F_ADDU));
        emit(itype(OP_ADDIU, 5'd0, 5'd21, 16'h007f));
        sec_start[4] = n_words;
        emit(itype(OP_BEQ, 5'd0, 5'd0, 16'hffff));    // Self-loop
        emit(32'h0);
    endtask

    function automatic logic [1:0] section_of(input logic [31:0] pc);
        logic [1:0] s;
        s = 2'd0;
        for (int i = 1; i < N_SEC; i++) begin
            if (pc >= 32'(sec_start[i] * 4)) s = 2'(i);
        end
        return s;
    endfunction

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0]  dest;
        exp_t        e;
        int          steps;
        pc    = 32'h0;
        npc   = 32'h4;
        steps = 0;
        while (pc != 32'(sec_start[N_SEC] * 4) && steps < 2000) begin
            w    = rom[pc[9:2]];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            dest = 5'd0;
            val  = 32'h0;
            nnpc = npc + 32'd4;
            case (opcode_e'(w[31:26]))
                OP_SPECIAL: begin
                    dest = w[15:11];
                    case (funct_e'(w[5:0]))
                        F_ADDU: val = a + b;
                        F_SUBU: val = a - b;
                        F_AND:  val = a & b;
                        F_OR:   val = a | b;
                        F_XOR:  val = a ^ b;
                        F_SLT:  val = {31'h0, $signed(a) < $signed(b)};
                        F_SLL:  val = b << w[10:6];
                        F_JR: begin
                            dest = 5'd0;
                            nnpc = a;
                        end
                        default: dest = 5'd0;
                    endcase
                end
                OP_ADDIU: begin
                    dest = w[20:16];
                    val  = addr;
                end
                OP_LUI: begin
                    dest = w[20:16];
                    val  = {w[15:0], 16'h0};
                end
                OP_LW: begin
                    dest = w[20:16];
                    val  = model_mem[addr[9:2]];
                end
                OP_LB: begin
                    dest = w[20:16];
                    val  = 32'($signed(model_mem[addr[9:2]][addr[1:0]*8 +: 8]));
                end
                OP_LBU: begin
                    dest = w[20:16];
                    val  = {24'h0, model_mem[addr[9:2]][addr[1:0]*8 +: 8]};
                end
                OP_SW: model_mem[addr[9:2]] = b;
                OP_SB: model_mem[addr[9:2]][addr[1:0]*8 +: 8] = b[7:0];
                OP_BEQ: if (a == b) nnpc = npc + (imm << 2);
                OP_BNE: if (a != b) nnpc = npc + (imm << 2);
                OP_J:   nnpc = {npc[31:28], w[25:0], 2'b00};
                OP_JAL: begin
                    nnpc = {npc[31:28], w[25:0], 2'b00};
                    dest = 5'd31;
                    val  = pc + 32'd8;
                end
                default: ;
            endcase
            if (dest != 5'd0) begin
                model_regs[dest] = val;
                e = '{pc: pc, num: dest, data: val, sec: section_of(pc)};
                exp_q.push_back(e);
                sec_total[e.sec]++;
            end
            pc    = npc;
            npc   = nnpc;
            steps = steps + 1;
        end
    endtask

    always @(posedge clk) begin
        exp_t e;
        if (arst_n && debug_wb_rf_wen != 4'h0) begin
            if (exp_q.size() == 0) begin
                $display("unexpected writeback from pc %h after the program ended", debug_wb_pc);
                other_err++;
            end else begin
                e = exp_q.pop_front();
                assert (debug_wb_pc == e.pc) else begin
                    $display("mismatch debug_wb_pc: got %h expected %h", debug_wb_pc, e.pc);
                    sec_err[e.sec]++;
                end
                assert (debug_wb_rf_wnum == e.num) else begin
                    $display("mismatch debug_wb_rf_wnum: got %h expected %h",
                             debug_wb_rf_wnum, e.num);
                    sec_err[e.sec]++;
                end
                assert (debug_wb_rf_wdata == e.data) else begin
                    $display("mismatch debug_wb_rf_wdata: got %h expected %h",
                             debug_wb_rf_wdata, e.data);
                    sec_err[e.sec]++;
                end
                assert (debug_wb_rf_wen == 4'hf) else begin
                    $display("mismatch debug_wb_rf_wen: got %h expected %h",
                             debug_wb_rf_wen, 4'hf);
                    sec_err[e.sec]++;
                end
                sec_seen[e.sec]++;
                if (sec_seen[e.sec] == sec_total[e.sec]) begin
                    $display("section %s: %0d writebacks, %0d errors", sec_name[e.sec],
                             sec_total[e.sec], sec_err[e.sec]);
                end
            end
        end
    end

    initial begin
        int limit;
        int errors;
        arst_n          = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        cycles          = 0;
        other_err       = 0;
        n_words         = 0;
        rng             = 32'h8e08;
        for (int i = 0; i < N_SEC; i++) begin
            sec_total[i] = 0;
            sec_seen[i]  = 0;
            sec_err[i]   = 0;
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'h0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i]       = 32'(i + 1) * 32'h9e37_79b1;
            model_mem[i] = ram[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        gen_program();
        run_model();
        limit = 6 * n_words + 50;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        while (exp_q.size() != 0 && cycles < limit) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);   // Catch stray writebacks
        if (exp_q.size() != 0) begin
            $display("timeout after %0d cycles with %0d writebacks still expected",
                     cycles, exp_q.size());
            other_err++;
        end
        errors = other_err + i_dut.u_checker.fail_cnt;
        for (int i = 0; i < N_SEC; i++) begin
            errors += sec_err[i];
        end
        $display("checked %0d program words, %0d assertion failures, %0d errors total",
                 n_words, i_dut.u_checker.fail_cnt, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verif/cpu_checker.sv */
module cpu_checker import cpu_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input logic [XLEN-1:0]   inst_sram_addr,
    input logic              data_sram_en,
    input logic [3:0]        data_sram_wen,
    input logic [3:0]        debug_wb_rf_wen,
    input logic [REG_AW-1:0] debug_wb_rf_wnum
);

    int fail_cnt = 0;

    // No side effects while in reset
    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (data_sram_wen == 4'h0 && debug_wb_rf_wen == 4'h0))
        else begin $error("store or writeback during reset"); fail_cnt++; end

    no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != '0)
        else begin $error("writeback to register 0 on the trace"); fail_cnt++; end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        inst_sram_addr[1:0] == 2'b00)
        else begin $error("fetch address not word aligned"); fail_cnt++; end

    wen_needs_en: assert property (@(posedge clk) disable iff (!arst_n)
        data_sram_wen != 4'h0 |-> data_sram_en)
        else begin $error("byte write enable without data enable"); fail_cnt++; end

endmodule

bind mycpu_top cpu_checker u_checker (
    .clk             (clk             ),
    .arst_n          (arst_n          ),
    .inst_sram_addr  (inst_sram_addr  ),
    .data_sram_en    (data_sram_en    ),
    .data_sram_wen   (data_sram_wen   ),
    .debug_wb_rf_wen (debug_wb_rf_wen ),
    .debug_wb_rf_wnum(debug_wb_rf_wnum)
);

/* logic/mycpu_top.sv */
module mycpu_top import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                arst_n,

    output logic                inst_sram_en,
    output logic [XLEN-1:0]     inst_sram_addr,
    input  logic [XLEN-1:0]     inst_sram_rdata,

    output logic                data_sram_en,
    output logic [3:0]          data_sram_wen,
    output logic [XLEN-1:0]     data_sram_addr,
    output logic [XLEN-1:0]     data_sram_wdata,
    input  logic [XLEN-1:0]     data_sram_rdata,

    output logic [XLEN-1:0]     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output logic [REG_AW-1:0]   debug_wb_rf_wnum,
    output logic [XLEN-1:0]     debug_wb_rf_wdata
);

    logic [XLEN-1:0]   fe_pc;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic              block;
    logic [REG_AW-1:0] rf_raddr1;
    logic [REG_AW-1:0] rf_raddr2;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    de_exe_t           de_exe;
    exe_mem_t          exe_mem;
    fwd_t              exe_fwd;
    fwd_t              mem_fwd;
    wb_t               wb;

    fetch_stage #(.RESET_PC(RESET_PC)) fe_stage (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .redirect       (redirect       ),
        .redirect_pc    (redirect_pc    ),
        .block          (block          ),
        .inst_sram_en   (inst_sram_en   ),
        .inst_sram_addr (inst_sram_addr ),
        .fe_pc          (fe_pc          )
    );

    decode_stage de_stage (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .fe_pc          (fe_pc          ),
        .inst           (inst_sram_rdata),
        .rf_raddr1      (rf_raddr1      ),
        .rf_raddr2      (rf_raddr2      ),
        .rf_rdata1      (rf_rdata1      ),
        .rf_rdata2      (rf_rdata2      ),
        .exe_fwd        (exe_fwd        ),
        .mem_fwd        (mem_fwd        ),
        .wb             (wb             ),
        .redirect       (redirect       ),
        .redirect_pc    (redirect_pc    ),
        .block          (block          ),
        .de_exe         (de_exe         )
    );

    execute_stage exe_stage (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .de_exe         (de_exe         ),
        .data_sram_en   (data_sram_en   ),
        .data_sram_wen  (data_sram_wen  ),
        .data_sram_addr (data_sram_addr ),
        .data_sram_wdata(data_sram_wdata),
        .exe_fwd        (exe_fwd        ),
        .exe_mem        (exe_mem        )
    );

    memory_stage mem_stage (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .exe_mem        (exe_mem        ),
        .data_sram_rdata(data_sram_rdata),
        .mem_fwd        (mem_fwd        ),
        .wb             (wb             )
    );

    reg_file rf (
        .clk            (clk            ),
        .arst_n         (arst_n         ),
        .wb             (wb             ),
        .raddr1         (rf_raddr1      ),
        .raddr2         (rf_raddr2      ),
        .rdata1         (rf_rdata1      ),
        .rdata2         (rf_rdata2      )
    );

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = {4{wb.wen}};
    assign debug_wb_rf_wnum  = wb.dest;
    assign debug_wb_rf_wdata = wb.data;

endmodule

/* logic/reg_file.sv */
module reg_file import cpu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  wb_t               wb,
    input  logic [REG_AW-1:0] raddr1,
    input  logic [REG_AW-1:0] raddr2,
    output logic [XLEN-1:0]   rdata1,
    output logic [XLEN-1:0]   rdata2
);

    logic [XLEN-1:0] regs [2**REG_AW];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.dest != '0) begin   // r0 stays zero
            regs[wb.dest] <= wb.data;
        end
    end

    // Old value on a same-cycle write
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

/* logic/memory_stage.sv */
module memory_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  exe_mem_t        exe_mem,
    input  logic [XLEN-1:0] data_sram_rdata,
    output fwd_t            mem_fwd,
    output wb_t             wb
);

    logic [7:0]      ld_byte;
    logic [XLEN-1:0] res;
    logic            is_load;

    assign ld_byte = data_sram_rdata[{exe_mem.addr_lo, 3'b000} +: 8];
    assign is_load = exe_mem.mem_op inside {MEM_LW, MEM_LB, MEM_LBU};

    always_comb begin
        case (exe_mem.mem_op)
            MEM_LW:  res = data_sram_rdata;
            MEM_LB:  res = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            MEM_LBU: res = {{(XLEN-8){1'b0}}, ld_byte};
            default: res = exe_mem.value;
        endcase
    end

    // Load data is already valid here, so decode can take it directly
    assign mem_fwd.dest    = exe_mem.dest;
    assign mem_fwd.value   = res;
    assign mem_fwd.valid   = exe_mem.valid && exe_mem.dest != '0;
    assign mem_fwd.is_load = is_load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.wen  <= exe_mem.valid && exe_mem.dest != '0;
            wb.dest <= exe_mem.dest;
            wb.data <= res;
            wb.pc   <= exe_mem.pc;
        end
    end

endmodule

/* logic/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  de_exe_t         de_exe,
    output logic            data_sram_en,
    output logic [3:0]      data_sram_wen,
    output logic [XLEN-1:0] data_sram_addr,
    output logic [XLEN-1:0] data_sram_wdata,
    output fwd_t            exe_fwd,
    output exe_mem_t        exe_mem
);

    logic [XLEN-1:0] result;
    logic            is_load;

    always_comb begin
        case (de_exe.alu_op)
            ALU_ADD: result = de_exe.src1 + de_exe.src2;
            ALU_SUB: result = de_exe.src1 - de_exe.src2;
            ALU_AND: result = de_exe.src1 & de_exe.src2;
            ALU_OR:  result = de_exe.src1 | de_exe.src2;
            ALU_XOR: result = de_exe.src1 ^ de_exe.src2;
            ALU_SLT: result = XLEN'($signed(de_exe.src1) < $signed(de_exe.src2));
            ALU_SLL: result = de_exe.src2 << de_exe.src1[4:0];
            ALU_LUI: result = {de_exe.src2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign is_load = de_exe.mem_op inside {MEM_LW, MEM_LB, MEM_LBU};

    always_comb begin
        data_sram_wen = 4'b0000;
        if (de_exe.valid && de_exe.mem_op == MEM_SW) begin
            data_sram_wen = 4'b1111;
        end else if (de_exe.valid && de_exe.mem_op == MEM_SB) begin
            data_sram_wen = 4'b0001 << result[1:0];   // One byte lane
        end
    end

    assign data_sram_en    = de_exe.valid && de_exe.mem_op != MEM_NONE;
    assign data_sram_addr  = {result[XLEN-1:2], 2'b00};
    assign data_sram_wdata = (de_exe.mem_op == MEM_SB) ? {4{de_exe.st_value[7:0]}}
                                                       : de_exe.st_value;

    assign exe_fwd.dest    = de_exe.dest;
    assign exe_fwd.value   = result;
    assign exe_fwd.valid   = de_exe.valid && de_exe.dest != '0;
    assign exe_fwd.is_load = is_load;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_mem <= '0;
        end else begin
            exe_mem.valid   <= de_exe.valid;
            exe_mem.pc      <= de_exe.pc;
            exe_mem.mem_op  <= de_exe.mem_op;
            exe_mem.value   <= result;
            exe_mem.addr_lo <= result[1:0];
            exe_mem.dest    <= de_exe.dest;
        end
    end

endmodule

/* logic/decode_stage.sv */
module decode_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [XLEN-1:0]   fe_pc,
    input  logic [XLEN-1:0]   inst,
    output logic [REG_AW-1:0] rf_raddr1,
    output logic [REG_AW-1:0] rf_raddr2,
    input  logic [XLEN-1:0]   rf_rdata1,
    input  logic [XLEN-1:0]   rf_rdata2,
    input  fwd_t              exe_fwd,
    input  fwd_t              mem_fwd,
    input  wb_t               wb,
    output logic              redirect,
    output logic [XLEN-1:0]   redirect_pc,
    output logic              block,
    output de_exe_t           de_exe
);

    opcode_e           op;
    funct_e            funct;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm_sext;
    logic [XLEN-1:0]   pc_plus4;
    logic [XLEN-1:0]   rs_val;
    logic [XLEN-1:0]   rt_val;
    logic              use_rs;
    logic              use_rt;
    logic              taken;
    de_exe_t           de_next;

    // Youngest producer wins
    function automatic logic [XLEN-1:0] bypass(
        input logic [REG_AW-1:0] addr,
        input logic [XLEN-1:0]   rf_val,
        input fwd_t              ex,
        input fwd_t              mm,
        input wb_t               wr
    );
        return (ex.valid && ex.dest == addr) ? ex.value :
               (mm.valid && mm.dest == addr) ? mm.value :
               (wr.wen && wr.dest == addr)   ? wr.data  : rf_val;
    endfunction

    assign op        = opcode_e'(inst[31:26]);
    assign funct     = funct_e'(inst[5:0]);
    assign rs        = inst[25:21];
    assign rt        = inst[20:16];
    assign rd        = inst[15:11];
    assign imm_sext  = {{16{inst[15]}}, inst[15:0]};
    assign pc_plus4  = fe_pc + 32'd4;
    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;
    assign rs_val    = bypass(rs, rf_rdata1, exe_fwd, mem_fwd, wb);
    assign rt_val    = bypass(rt, rf_rdata2, exe_fwd, mem_fwd, wb);

    always_comb begin
        de_next          = '0;
        de_next.valid    = 1'b1;
        de_next.pc       = fe_pc;
        de_next.alu_op   = ALU_ADD;
        de_next.mem_op   = MEM_NONE;
        de_next.src1     = rs_val;
        de_next.src2     = imm_sext;
        de_next.st_value = rt_val;
        de_next.dest     = rt;
        use_rs           = 1'b1;
        use_rt           = 1'b0;
        taken            = 1'b0;
        redirect_pc      = pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};
        case (op)
            OP_SPECIAL: begin
                de_next.src2 = rt_val;
                de_next.dest = rd;
                use_rt       = 1'b1;
                case (funct)
                    F_ADDU: de_next.alu_op = ALU_ADD;
                    F_SUBU: de_next.alu_op = ALU_SUB;
                    F_AND:  de_next.alu_op = ALU_AND;
                    F_OR:   de_next.alu_op = ALU_OR;
                    F_XOR:  de_next.alu_op = ALU_XOR;
                    F_SLT:  de_next.alu_op = ALU_SLT;
                    F_SLL: begin
                        de_next.alu_op = ALU_SLL;
                        de_next.src1   = XLEN'(inst[10:6]);  // Shift amount
                        use_rs         = 1'b0;
                    end
                    F_JR: begin
                        de_next.dest = '0;
                        taken        = 1'b1;
                        redirect_pc  = rs_val;
                    end
                    default: de_next.dest = '0;
                endcase
            end
            OP_ADDIU: de_next.alu_op = ALU_ADD;
            OP_LUI: begin
                de_next.alu_op = ALU_LUI;
                use_rs         = 1'b0;
            end
            OP_LW:  de_next.mem_op = MEM_LW;
            OP_LB:  de_next.mem_op = MEM_LB;
            OP_LBU: de_next.mem_op = MEM_LBU;
            OP_SW, OP_SB: begin
                de_next.mem_op = (op == OP_SW) ? MEM_SW : MEM_SB;
                de_next.dest   = '0;
                use_rt         = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                de_next.dest = '0;
                use_rt       = 1'b1;
                taken        = (rs_val == rt_val) ^ (op == OP_BNE);
            end
            OP_J, OP_JAL: begin
                de_next.dest = (op == OP_JAL) ? REG_AW'(31) : '0;
                de_next.src1 = pc_plus4 + 32'd4;   // Link value
                de_next.src2 = '0;
                use_rs       = 1'b0;
                taken        = 1'b1;
                redirect_pc  = {pc_plus4[31:28], inst[25:0], 2'b00};
            end
            default: begin
                de_next.dest = '0;
                use_rs       = 1'b0;
            end
        endcase
    end

    // Load result is not ready until the memory stage
    assign block = exe_fwd.valid && exe_fwd.is_load &&
                   ((use_rs && exe_fwd.dest == rs) || (use_rt && exe_fwd.dest == rt));
    assign redirect = taken && !block;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_exe <= '0;
        end else if (block) begin
            de_exe.valid <= 1'b0;    // Bubble
        end else begin
            de_exe <= de_next;
        end
    end

endmodule

/* logic/fetch_stage.sv */
module fetch_stage import cpu_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            block,
    output logic            inst_sram_en,
    output logic [XLEN-1:0] inst_sram_addr,
    output logic [XLEN-1:0] fe_pc
);

    logic [XLEN-1:0] next_pc;
    logic            pend;       // Target waits for the delay slot
    logic [XLEN-1:0] pend_pc;

    always_comb begin
        if (!arst_n) begin
            next_pc = RESET_PC;
        end else if (block) begin
            next_pc = fe_pc;     // Refetch the stalled instruction
        end else if (pend) begin
            next_pc = pend_pc;
        end else begin
            next_pc = fe_pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fe_pc   <= RESET_PC;
            pend    <= 1'b0;
            pend_pc <= '0;
        end else begin
            fe_pc <= next_pc;
            if (redirect) begin
                pend    <= 1'b1;
                pend_pc <= redirect_pc;
            end else if (!block) begin
                pend <= 1'b0;
            end
        end
    end

    assign inst_sram_en   = 1'b1;
    assign inst_sram_addr = next_pc;

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB
    } mem_op_e;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LB      = 6'h20,
        OP_LW      = 6'h23,
        OP_LBU     = 6'h24,
        OP_SB      = 6'h28,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        alu_op_e           alu_op;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   src1;
        logic [XLEN-1:0]   src2;
        logic [XLEN-1:0]   st_value;
        logic [REG_AW-1:0] dest;     // 0 means no write
    } de_exe_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        mem_op_e           mem_op;
        logic [XLEN-1:0]   value;    // ALU result or load address
        logic [1:0]        addr_lo;
        logic [REG_AW-1:0] dest;
    } exe_mem_t;

    typedef struct packed {
        logic              wen;
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   pc;
    } wb_t;

    typedef struct packed {
        logic [REG_AW-1:0] dest;
        logic [XLEN-1:0]   value;
        logic              valid;
        logic              is_load;
    } fwd_t;

endpackage
